//--- u712Pkg.sv
////////////////////////////////////////////////////////////
// Shared types and timing for the 68040 chip bus glue
// Holds the transfer size encoding, the CPU request, the
// 68000-style strobe group and the chip RAM control group
// Import with u712Pkg::* in the module header
////////////////////////////////////////////////////////////

package u712Pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // CPU address reaching the glue, A20..A0
    localparam int ADDR_W = 21;
    // Multiplexed DRAM address
    localparam int MA_W = 11;
    // Row split point in the CPU address
    localparam int ROW_LSB = 11;
    // Column is A10..A1, one word per step
    localparam int COL_W = ROW_LSB - 1;
    localparam int LANES = 4;

    ////////////////////////////////////////////////////////////
    // Timing in clk40 cycles
    ////////////////////////////////////////////////////////////

    // Strobes held this long once the chipset grant is seen
    localparam int REG_HOLD_CYCLES = 6;
    localparam int RAS_TO_CAS = 2;
    localparam int CAS_TO_DONE = 2;
    // Longwords in one 16 byte line
    localparam int LINE_BEATS = 4;
    // Column step per line beat, two words per longword
    localparam int COL_STEP = 2;

    // Counter widths
    localparam int HOLD_W = $clog2(REG_HOLD_CYCLES);
    localparam int DLY_W = $clog2(RAS_TO_CAS > CAS_TO_DONE ? RAS_TO_CAS : CAS_TO_DONE) + 1;
    localparam int BEAT_W = $clog2(LINE_BEATS + 1);

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    // SIZ1:SIZ0 as driven by the 68040
    typedef enum logic [1:0] {
        SIZE_LONG = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_LINE = 2'b11
    } sizeT;

    // One CPU transfer, stable from tsN to the last taN
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        sizeT              siz;
        logic              rnw;
    } cpuReqT;

    // 68000-style register cycle strobes
    typedef struct packed {
        logic asN;
        logic udsN;
        logic ldsN;
        logic rwN;
    } busStrobeT;

    // Chip RAM control, casN[3] is lane 0
    typedef struct packed {
        logic             rasN;
        logic [LANES-1:0] casN;
        logic             weN;
        logic [MA_W-1:0]  ma;
    } dramCtlT;

    // Idle values, all strobes high and rwN at read
    localparam busStrobeT STROBE_IDLE = '{asN: 1'b1, udsN: 1'b1, ldsN: 1'b1, rwN: 1'b1};
    localparam dramCtlT DRAM_IDLE = '{rasN: 1'b1, casN: '1, weN: 1'b1, ma: '0};

endpackage

//--- laneDecode.sv
////////////////////////////////////////////////////////////
// Byte lane decode for 68040 transfers
// Turns size and A1..A0 into four active-low lane enables
// Bit 3 is lane 0, the most significant byte D31..D24
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module laneDecode import u712Pkg::*; (
    input  sizeT             siz,
    input  logic [1:0]       addrLow,
    output logic [LANES-1:0] laneEnN
);

    // One-hot lane pick, lane 0 in the top bit
    logic [LANES-1:0] byteSel;
    // Upper or lower half of the longword
    logic [LANES-1:0] wordSel;

    assign byteSel = 4'b1000 >> addrLow;
    assign wordSel = addrLow[1] ? 4'b0011 : 4'b1100;

    always_comb begin
        case (siz)
            SIZE_BYTE: begin
                laneEnN = ~byteSel;
            end
            SIZE_WORD: begin
                // A0 ignored, words are aligned
                laneEnN = ~wordSel;
            end
            SIZE_LONG,
            SIZE_LINE: begin
                laneEnN = '0;
            end
            default: begin
                laneEnN = '1;
            end
        endcase
    end

endmodule

//--- registerCycle.sv
////////////////////////////////////////////////////////////
// Chipset register cycle engine
// Starts on start, drives 68000-style AS/UDS/LDS/RW to the
// chipset, waits for the bus grant dbrN, holds the strobes
// a fixed count and then pulses regDone for one cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module registerCycle import u712Pkg::*; (
    input  logic             clk40,
    input  logic             rstN,
    input  logic             start,
    input  logic             rnw,
    input  logic [LANES-1:0] laneEnN,
    input  logic             dbrN,
    output busStrobeT        busStrobe,
    output logic             regDone
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        HOLD
    } regStateT;

    regStateT state;
    logic [HOLD_W-1:0] holdCnt;

    // 16 bit chipset bus strobes from the lane pair
    logic udsSelN;
    logic ldsSelN;

    ////////////////////////////////////////////////////////////
    // Lane to data strobe mapping
    ////////////////////////////////////////////////////////////

    // Even lanes land on D15..D8
    assign udsSelN = laneEnN[3] & laneEnN[1];
    // Odd lanes on D7..D0
    assign ldsSelN = laneEnN[2] & laneEnN[0];

    ////////////////////////////////////////////////////////////
    // Cycle FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            holdCnt   <= '0;
            busStrobe <= STROBE_IDLE;
            regDone   <= 1'b0;
        end else begin
            // Done is a single cycle pulse
            regDone <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state          <= WAIT_GRANT;
                        busStrobe.asN  <= 1'b0;
                        busStrobe.udsN <= udsSelN;
                        busStrobe.ldsN <= ldsSelN;
                        busStrobe.rwN  <= rnw;
                    end
                end
                WAIT_GRANT: begin
                    // Chipset owns the bus until dbrN drops
                    if (!dbrN) begin
                        state   <= HOLD;
                        holdCnt <= HOLD_W'(REG_HOLD_CYCLES - 1);
                    end
                end
                HOLD: begin
                    if (holdCnt == '0) begin
                        // Release strobes with the done pulse
                        state     <= IDLE;
                        busStrobe <= STROBE_IDLE;
                        regDone   <= 1'b1;
                    end else begin
                        holdCnt <= holdCnt - 1'b1;
                    end
                end
                default: begin
                    state     <= IDLE;
                    busStrobe <= STROBE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- ramCycle.sv
////////////////////////////////////////////////////////////
// Chip RAM cycle engine
// Sequences RAS, CAS and WE with a row/column multiplexed
// address. Single transfers give one beat, line transfers
// give four beats with a one cycle CAS precharge between
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ramCycle import u712Pkg::*; (
    input  logic             clk40,
    input  logic             rstN,
    input  logic             start,
    input  cpuReqT           req,
    input  logic [LANES-1:0] laneEnN,
    output dramCtlT          dramCtl,
    output logic             ramDone,
    output logic             ramLast
);

    typedef enum logic [1:0] {
        IDLE,
        ROW_ACTIVE,
        COL_ACTIVE,
        PRECHARGE
    } ramStateT;

    ramStateT state;
    logic [DLY_W-1:0]  delayCnt;
    logic [BEAT_W-1:0] beatsLeft;
    logic [COL_W-1:0]  colAddr;

    logic [MA_W-1:0] rowMa;
    logic [MA_W-1:0] colMa;
    logic beatEnd;
    logic finalBeat;

    ////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////

    // Row is A20..A11, zero extended
    assign rowMa = {1'b0, req.addr[ADDR_W-1:ROW_LSB]};
    assign colMa = {1'b0, colAddr};

    assign beatEnd = (state == COL_ACTIVE) && (delayCnt == '0);
    assign finalBeat = (beatsLeft == BEAT_W'(1));

    // Column pointer, loaded at start and stepped per beat
    always_ff @(posedge clk40) begin
        if (state == IDLE && start) begin
            colAddr <= req.addr[ROW_LSB-1:1];
        end else if (beatEnd && !finalBeat) begin
            colAddr <= colAddr + COL_W'(COL_STEP);
        end
    end

    ////////////////////////////////////////////////////////////
    // DRAM FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            delayCnt  <= '0;
            beatsLeft <= '0;
            dramCtl   <= DRAM_IDLE;
            ramDone   <= 1'b0;
            ramLast   <= 1'b0;
        end else begin
            ramDone <= 1'b0;
            ramLast <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        // Open the row, WE follows direction
                        state        <= ROW_ACTIVE;
                        delayCnt     <= DLY_W'(RAS_TO_CAS - 1);
                        beatsLeft    <= (req.siz == SIZE_LINE) ? BEAT_W'(LINE_BEATS)
                                                               : BEAT_W'(1);
                        dramCtl.rasN <= 1'b0;
                        dramCtl.weN  <= req.rnw;
                        dramCtl.ma   <= rowMa;
                    end
                end
                ROW_ACTIVE: begin
                    if (delayCnt == '0) begin
                        state        <= COL_ACTIVE;
                        delayCnt     <= DLY_W'(CAS_TO_DONE - 1);
                        dramCtl.casN <= laneEnN;
                        dramCtl.ma   <= colMa;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                COL_ACTIVE: begin
                    if (delayCnt == '0) begin
                        ramDone      <= 1'b1;
                        beatsLeft    <= beatsLeft - 1'b1;
                        dramCtl.casN <= '1;
                        if (finalBeat) begin
                            // Close the row with the last beat
                            state   <= IDLE;
                            ramLast <= 1'b1;
                            dramCtl <= DRAM_IDLE;
                        end else begin
                            state <= PRECHARGE;
                        end
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                PRECHARGE: begin
                    // One cycle CAS high, row stays open
                    state        <= COL_ACTIVE;
                    delayCnt     <= DLY_W'(CAS_TO_DONE - 1);
                    dramCtl.casN <= laneEnN;
                    dramCtl.ma   <= colMa;
                end
                default: begin
                    state   <= IDLE;
                    dramCtl <= DRAM_IDLE;
                end
            endcase
        end
    end

endmodule

//--- transferAck.sv
////////////////////////////////////////////////////////////
// 68040 transfer acknowledge merge
// One registered taN from both engines' done pulses, with
// tbiN to stop bursting on chipset register cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module transferAck (
    input  logic clk40,
    input  logic rstN,
    input  logic regDone,
    input  logic ramDone,
    output logic taN,
    output logic tbiN
);

    // Any engine finishing a beat
    logic anyDone;

    assign anyDone = regDone | ramDone;

    ////////////////////////////////////////////////////////////
    // Registered acknowledge
    ////////////////////////////////////////////////////////////

    // Engines never finish in the same cycle
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            taN <= 1'b1;
        end else begin
            // Low for exactly one cycle per done pulse
            taN <= ~anyDone;
        end
    end

    // Burst inhibit rides along with register acks only
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            tbiN <= 1'b1;
        end else begin
            tbiN <= ~regDone;
        end
    end

endmodule

//--- u712Top.sv
////////////////////////////////////////////////////////////
// 68040 to chipset bus glue, top level
// Decodes lanes, runs the register and chip RAM engines and
// merges their completions into taN and tbiN
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module u712Top import u712Pkg::*; (
    input  logic             clk40,
    input  logic             rstN,
    input  logic             tsN,
    input  logic             regSpaceN,
    input  logic             ramSpaceN,
    input  logic             dbrN,
    input  cpuReqT           cpuReq,
    output logic             taN,
    output logic             tbiN,
    output busStrobeT        busStrobe,
    output dramCtlT          dramCtl,
    output logic [LANES-1:0] laneEnN
);

    logic regStart;
    logic ramStart;
    logic regDone;
    logic ramDone;
    // Marks the end of a RAM transfer for protocol checks
    logic ramLast;

    // Exactly one space select must be low
    assign regStart = !tsN && !regSpaceN && ramSpaceN;
    assign ramStart = !tsN && !ramSpaceN && regSpaceN;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    laneDecode laneDecode_i (
        .siz     (cpuReq.siz),
        .addrLow (cpuReq.addr[1:0]),
        .laneEnN (laneEnN)
    );

    registerCycle registerCycle_i (
        .clk40     (clk40),
        .rstN      (rstN),
        .start     (regStart),
        .rnw       (cpuReq.rnw),
        .laneEnN   (laneEnN),
        .dbrN      (dbrN),
        .busStrobe (busStrobe),
        .regDone   (regDone)
    );

    ramCycle ramCycle_i (
        .clk40   (clk40),
        .rstN    (rstN),
        .start   (ramStart),
        .req     (cpuReq),
        .laneEnN (laneEnN),
        .dramCtl (dramCtl),
        .ramDone (ramDone),
        .ramLast (ramLast)
    );

    transferAck transferAck_i (
        .clk40   (clk40),
        .rstN    (rstN),
        .regDone (regDone),
        .ramDone (ramDone),
        .taN     (taN),
        .tbiN    (tbiN)
    );

endmodule

//--- u712Top_asserts.sv
////////////////////////////////////////////////////////////
// Bus protocol checks for the chip bus glue
// Bound into u712Top, watches taN, the engine done pulses,
// tsN overlap and CAS against RAS
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module u712TopAsserts import u712Pkg::*; (
    input logic    clk40,
    input logic    rstN,
    input logic    tsN,
    input logic    regSpaceN,
    input logic    ramSpaceN,
    input logic    taN,
    input logic    regDone,
    input logic    ramDone,
    input logic    ramLast,
    input dramCtlT dramCtl
);

    // Accepted transfer still waiting for its last done
    logic busy;

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (regDone || ramLast) begin
            busy <= 1'b0;
        end else if (!tsN && (regSpaceN != ramSpaceN)) begin
            busy <= 1'b1;
        end
    end

    ackPulse: assert property (@(posedge clk40) disable iff (!rstN) !taN |=> taN)
        else $error("taN held low for two cycles");

    oneDone: assert property (@(posedge clk40) disable iff (!rstN) !(regDone && ramDone))
        else $error("Both engines finished in the same cycle");

    noOverlap: assert property (@(posedge clk40) disable iff (!rstN) busy |-> tsN)
        else $error("tsN asserted while a transfer was outstanding");

    casUnderRas: assert property (@(posedge clk40) disable iff (!rstN)
                                  dramCtl.rasN |-> (&dramCtl.casN))
        else $error("casN low while rasN high");

endmodule

bind u712Top u712TopAsserts u712TopAsserts_i (
    .clk40     (clk40),
    .rstN      (rstN),
    .tsN       (tsN),
    .regSpaceN (regSpaceN),
    .ramSpaceN (ramSpaceN),
    .taN       (taN),
    .regDone   (regDone),
    .ramDone   (ramDone),
    .ramLast   (ramLast),
    .dramCtl   (dramCtl)
);

//--- u712Tb.sv
////////////////////////////////////////////////////////////
// Testbench for the 68040 chip bus glue
// Reads one transfer per line from u712Vectors.txt, drives
// it into the DUT and checks lanes, register strobes, chip
// RAM control, taN timing and tbiN against the bus rules
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module u712Tb import u712Pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int SEED_INIT = 70043;
    // Watchdog cycles per transfer on top of the longest grant delay
    localparam int WATCH_PER_VEC = 20;
    localparam int WATCH_BASE = 100;
    // Longest wait for one taN once the grant is given
    localparam int ACK_TIMEOUT = 64;
    localparam int IDLE_GAP = 2;

    // All strobes high with rwN at read and ma parked at 0
    localparam busStrobeT IDLE_STROBE = busStrobeT'(4'b1111);
    localparam dramCtlT IDLE_DRAM = dramCtlT'({1'b1, 4'b1111, 1'b1, 11'h000});

    // One line of the vector file
    typedef struct packed {
        logic              isRam;
        logic              rnw;
        sizeT              siz;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        dbrDelay;
        logic [LANES-1:0]  lanes;
        logic [3:0]        beats;
        logic              tbi;
    } vecT;

    logic             clk40;
    logic             rstN;
    logic             tsN;
    logic             regSpaceN;
    logic             ramSpaceN;
    logic             dbrN;
    cpuReqT           cpuReq;
    logic             taN;
    logic             tbiN;
    busStrobeT        busStrobe;
    dramCtlT          dramCtl;
    logic [LANES-1:0] laneEnN;

    vecT    vecs[$];
    integer seed;
    int     watchCycles = 0;

    u712Top u712Top_i (
        .clk40     (clk40),
        .rstN      (rstN),
        .tsN       (tsN),
        .regSpaceN (regSpaceN),
        .ramSpaceN (ramSpaceN),
        .dbrN      (dbrN),
        .cpuReq    (cpuReq),
        .taN       (taN),
        .tbiN      (tbiN),
        .busStrobe (busStrobe),
        .dramCtl   (dramCtl),
        .laneEnN   (laneEnN)
    );

    initial begin
        clk40 = 1'b0;
        forever #(CLK_PERIOD / 2) clk40 = ~clk40;
    end

    ////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkLanes(input string name, input logic [LANES-1:0] exp,
                              input logic [LANES-1:0] act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic checkStrobe(input string name, input busStrobeT exp, input busStrobeT act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR %s: expected as/uds/lds/rw %b actual %b",
                               name, exp, act));
        end
    endtask

    task automatic checkDram(input string name, input dramCtlT exp, input dramCtlT act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR %s: expected ras %b cas %b we %b ma %h actual %b %b %b %h",
                               name, exp.rasN, exp.casN, exp.weN, exp.ma,
                               act.rasN, act.casN, act.weN, act.ma));
        end
    endtask

    task automatic checkAck(input string name, input int exp, input int act);
        if (act !== exp) begin
            abortRun($sformatf("ERROR %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic checkIdle(input string name);
        checkStrobe({name, " strobe"}, IDLE_STROBE, busStrobe);
        checkDram({name, " dram"}, IDLE_DRAM, dramCtl);
        checkAck({name, " taN"}, 1, int'(taN));
        checkAck({name, " tbiN"}, 1, int'(tbiN));
    endtask

    ////////////////////////////////////////////////////////////
    // Expected chip RAM control per cycle after acceptance
    ////////////////////////////////////////////////////////////

    function automatic dramCtlT expectDram(input vecT v, input int c);
        dramCtlT          d;
        int               k;
        int               beat;
        int               phase;
        logic [COL_W-1:0] col;
        d = IDLE_DRAM;
        if (c < RAS_TO_CAS) begin
            // Row open with WE low only for writes
            d.rasN = 1'b0;
            d.weN  = v.rnw;
            d.ma   = {1'b0, v.addr[ADDR_W-1:ROW_LSB]};
        end else begin
            // Each beat is CAS active then one precharge cycle
            k     = c - RAS_TO_CAS;
            beat  = k / (CAS_TO_DONE + 1);
            phase = k % (CAS_TO_DONE + 1);
            // Column steps two words per longword beat
            col   = v.addr[ROW_LSB-1:1] + COL_W'(2 * beat);
            if (beat < int'(v.beats) &&
                !(beat == int'(v.beats) - 1 && phase == CAS_TO_DONE)) begin
                d.rasN = 1'b0;
                d.weN  = v.rnw;
                d.ma   = {1'b0, col};
                if (phase < CAS_TO_DONE) begin
                    d.casN = v.lanes;
                end
            end
        end
        return d;
    endfunction

    ////////////////////////////////////////////////////////////
    // Vector loading
    ////////////////////////////////////////////////////////////

    task automatic loadVectors();
        int                fd;
        int                n;
        int                isRam;
        int                rnw;
        int                siz;
        int                dly;
        int                beats;
        int                tbi;
        int                maxDly;
        logic [ADDR_W-1:0] addr;
        logic [LANES-1:0]  lanes;
        string             line;
        vecT               v;
        maxDly = 0;
        fd = $fopen("u712Vectors.txt", "r");
        if (fd == 0) begin
            abortRun("Could not open the vector file u712Vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Lines opening with # are column notes
            if (line.len() > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%d %d %d %h %d %b %d %d",
                            isRam, rnw, siz, addr, dly, lanes, beats, tbi);
                if (n != 8) begin
                    abortRun("The vector file holds a line with missing fields");
                end
                v.isRam    = isRam[0];
                v.rnw      = rnw[0];
                v.siz      = sizeT'(siz[1:0]);
                v.addr     = addr;
                v.dbrDelay = dly[7:0];
                v.lanes    = lanes;
                v.beats    = beats[3:0];
                v.tbi      = tbi[0];
                vecs.push_back(v);
                if (dly > maxDly) begin
                    maxDly = dly;
                end
            end
        end
        $fclose(fd);
        watchCycles = vecs.size() * (maxDly + WATCH_PER_VEC) + WATCH_BASE;
    endtask

    ////////////////////////////////////////////////////////////
    // Transfer sequences
    ////////////////////////////////////////////////////////////

    // Drive the request and check lanes up to the acceptance edge
    task automatic startTransfer(input vecT v, input string name);
        cpuReqT req;
        req.addr = v.addr;
        req.siz  = v.siz;
        req.rnw  = v.rnw;
        @(posedge clk40);
        cpuReq    <= req;
        tsN       <= 1'b0;
        regSpaceN <= v.isRam;
        ramSpaceN <= ~v.isRam;
        @(negedge clk40);
        checkLanes({name, " lanes"}, v.lanes, laneEnN);
        @(posedge clk40);
        tsN       <= 1'b1;
        regSpaceN <= 1'b1;
        ramSpaceN <= 1'b1;
    endtask

    task automatic runRegister(input vecT v, input string name, output int beats);
        busStrobeT active;
        int        extra;
        int        g;
        // Byte cycles strobe UDS on even and LDS on odd addresses
        active.asN  = 1'b0;
        active.udsN = (v.siz == SIZE_BYTE) ? v.addr[0] : 1'b0;
        active.ldsN = (v.siz == SIZE_BYTE) ? ~v.addr[0] : 1'b0;
        active.rwN  = v.rnw;
        extra = int'(v.dbrDelay) + int'($unsigned($random(seed)) % 4);
        @(negedge clk40);
        checkStrobe({name, " strobe"}, active, busStrobe);
        // No ack while the chipset holds off the grant
        repeat (extra) begin
            @(negedge clk40);
            checkStrobe({name, " waiting strobe"}, active, busStrobe);
            checkAck({name, " taN before grant"}, 1, int'(taN));
        end
        @(posedge clk40);
        dbrN <= 1'b0;
        g = 0;
        @(negedge clk40);
        while (taN) begin
            if (g > ACK_TIMEOUT) begin
                abortRun("No taN arrived after the chipset grant");
            end
            if (g <= REG_HOLD_CYCLES) begin
                checkStrobe({name, " held strobe"}, active, busStrobe);
            end else begin
                checkStrobe({name, " released strobe"}, IDLE_STROBE, busStrobe);
            end
            @(negedge clk40);
            g++;
        end
        // Grant seen one edge later then the hold count and the ack register
        checkAck({name, " ack cycle"}, REG_HOLD_CYCLES + 2, g);
        checkAck({name, " tbiN"}, int'(v.tbi), int'(tbiN));
        checkStrobe({name, " strobe at taN"}, IDLE_STROBE, busStrobe);
        beats = 1;
    endtask

    task automatic runRam(input vecT v, input string name, output int beats);
        int lastC;
        int c;
        beats = 0;
        lastC = RAS_TO_CAS + CAS_TO_DONE + 1 + (int'(v.beats) - 1) * (CAS_TO_DONE + 1);
        for (c = 0; c <= lastC; c++) begin
            @(negedge clk40);
            checkDram($sformatf("%s dram c%0d", name, c), expectDram(v, c), dramCtl);
            checkStrobe({name, " register strobe"}, IDLE_STROBE, busStrobe);
            if (!taN) begin
                checkAck({name, " ack cycle"},
                         RAS_TO_CAS + CAS_TO_DONE + 1 + beats * (CAS_TO_DONE + 1), c);
                checkAck({name, " tbiN"}, int'(v.tbi), int'(tbiN));
                beats++;
            end
        end
    endtask

    // Quiet gap after each transfer where extra acks count as beats
    task automatic finishTransfer(input vecT v, input string name, input int beats);
        int seen;
        seen = beats;
        @(posedge clk40);
        dbrN <= 1'b1;
        repeat (IDLE_GAP) begin
            @(negedge clk40);
            if (!taN) begin
                seen++;
            end else begin
                checkIdle({name, " gap"});
            end
        end
        checkAck({name, " beats"}, int'(v.beats), seen);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int    beats;
        string name;
        rstN      <= 1'b0;
        tsN       <= 1'b1;
        regSpaceN <= 1'b1;
        ramSpaceN <= 1'b1;
        dbrN      <= 1'b1;
        cpuReq    <= '0;
        seed      = SEED_INIT;
        loadVectors();
        repeat (RESET_CYCLES - 1) @(posedge clk40);
        @(negedge clk40);
        checkIdle("in reset");
        @(posedge clk40);
        rstN <= 1'b1;
        @(negedge clk40);
        checkIdle("after reset");
        foreach (vecs[i]) begin
            name = $sformatf("vec%0d %s", i, vecs[i].isRam ? "ram" : "reg");
            startTransfer(vecs[i], name);
            if (vecs[i].isRam) begin
                runRam(vecs[i], name, beats);
            end else begin
                runRegister(vecs[i], name, beats);
            end
            finishTransfer(vecs[i], name, beats);
        end
        if (vecs.size() > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abortRun("The vector file held no transfers to run");
        end
    end

    initial begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clk40);
        abortRun("Watchdog expired before all transfers completed");
    end

endmodule

//--- u712Vectors.txt
# space(0 reg 1 ram) rnw siz(0 long 1 byte 2 word 3 line) addr(hex)
# dbrDelay laneEnN(binary, lane 0 first) beats tbiN
0 1 1 0DF000 0 0111 1 0
0 0 1 0DF001 3 1011 1 0
0 1 1 0DF002 1 1101 1 0
0 0 1 0DF003 5 1110 1 0
0 1 2 0DF004 2 0011 1 0
0 0 2 0DF09A 7 1100 1 0
0 1 0 0DF100 4 0000 1 0
0 0 0 0DF0C2 0 0000 1 0
0 1 2 0DF01E 9 1100 1 0
1 1 0 012344 0 0000 1 1
1 0 1 1A5673 0 1110 1 1
1 0 2 0ABCDE 0 1100 1 1
1 1 2 155551 0 0011 1 1
1 1 1 000002 0 1101 1 1
1 1 3 0F0010 0 0000 4 1
1 0 3 1FFFF0 0 0000 4 1
1 1 3 080A40 0 0000 4 1
1 0 0 1C0004 0 0000 1 1

//--- files.f
u712Pkg.sv
laneDecode.sv
registerCycle.sv
ramCycle.sv
transferAck.sv
u712Top.sv
u712Top_asserts.sv
u712Tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the chip bus glue testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f files.f --top-module u712Tb -o u712Sim \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

# A non-zero exit, such as a failed assertion, also counts as a failure
./obj_dir/u712Sim > sim.log 2>&1 || echo "TESTS FAILED (simulator exit status)" >> sim.log
cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
